// ==== include/history_buf_cfg.svh ====
/* sizes of the frame history buffer; MAX_BBOX must equal 2**OFFSET_WIDTH
   and HIST_DEPTH must be a power of two, since slot and offset are concatenated */
`ifndef HISTORY_BUF_CFG_SVH
`define HISTORY_BUF_CFG_SVH

// --------------------
// descriptor data
// --------------------
// one bounding box descriptor
`define DATA_WIDTH 32

// frame serial number, frames 0..255
`define FRAME_NUM_WIDTH 8

// --------------------
// history ring
// --------------------
// ring slots, one frame each
`define HIST_DEPTH 4
// holds a history count 0..HIST_DEPTH
`define HIST_DEPTH_WIDTH 3
// slot index, log2 of HIST_DEPTH
`define HIST_SLOT_WIDTH 2

// --------------------
// boxes per frame
// --------------------
`define MAX_BBOX 8
`define BBOX_CNT_WIDTH 4
// word offset inside one slot, pairs at even/odd
`define OFFSET_WIDTH 3

`endif

// ==== source/bbox_data_pkg.sv ====
/* types of the stored descriptors and of the addresses into the history ring */
`include "history_buf_cfg.svh"

package bbox_data_pkg;

	// one box descriptor as written by the PEs
	typedef logic [`DATA_WIDTH-1:0] bbox_t;

	// serial number of a video frame
	typedef logic [`FRAME_NUM_WIDTH-1:0] frame_num_t;

	// word offset inside a frame slot
	typedef logic [`OFFSET_WIDTH-1:0] offset_t;

	// ring slot index, low bits of the frame number
	typedef logic [`HIST_SLOT_WIDTH-1:0] slot_t;

	// history count, 0 means no history frame
	typedef logic [`HIST_DEPTH_WIDTH-1:0] hist_cnt_t;

	// number of boxes in a frame, also used for pair counts
	typedef logic [`BBOX_CNT_WIDTH-1:0] bbox_cnt_t;

endpackage

// ==== source/history_ctrl_pkg.sv ====
/* control encodings of the history buffer FSM and of the memory access mode */
package history_ctrl_pkg;

	// --------------------
	// FSM states
	// --------------------
	typedef enum logic [2:0] {
		// waiting for a start pulse
		st_idle            = 3'd0,
		// one descriptor pair per clock
		st_write           = 3'd1,
		// frame start held off by ready_from_core
		st_read_wait_ready = 3'd2,
		// offset registered, memory read in flight
		st_read_line       = 3'd3,
		// line on data_out until read_new_line
		st_read_hold       = 3'd4,
		// step to the next older frame
		st_read_next_frame = 3'd5
	} buf_state_e;

	// --------------------
	// access mode
	// --------------------
	typedef enum logic {
		acc_read  = 1'b0,
		acc_write = 1'b1
	} access_e;

endpackage

// ==== source/history_frame_mem.sv ====
/* ring of HIST_DEPTH frame slots, two words written or read per clock;
   read data appears one clock after the offsets, no read while we is high */
`timescale 1ns/1ns
`include "history_buf_cfg.svh"

module history_frame_mem (
	input logic clk,
	input logic rst,
	// frame select, slot is frame_num modulo HIST_DEPTH
	input bbox_data_pkg::frame_num_t frame_num,
	input logic we,
	// even and odd word of one pair
	input bbox_data_pkg::offset_t offset_0,
	input bbox_data_pkg::offset_t offset_1,
	input bbox_data_pkg::bbox_t data_in_0,
	input bbox_data_pkg::bbox_t data_in_1,
	output bbox_data_pkg::bbox_t data_out_0,
	output bbox_data_pkg::bbox_t data_out_1
);

	localparam int MEM_WORDS = `HIST_DEPTH * `MAX_BBOX;
	localparam int ADDR_WIDTH = `HIST_SLOT_WIDTH + `OFFSET_WIDTH;

	// --------------------
	// storage
	// --------------------
	// flat array, slot in the upper address bits
	bbox_data_pkg::bbox_t mem [0:MEM_WORDS-1];

	bbox_data_pkg::slot_t slot;
	logic [ADDR_WIDTH-1:0] addr_0;
	logic [ADDR_WIDTH-1:0] addr_1;

	// low bits of the frame number pick the ring slot
	assign slot = frame_num[`HIST_SLOT_WIDTH-1:0];

	assign addr_0 = {slot, offset_0};
	assign addr_1 = {slot, offset_1};

	// --------------------
	// write port
	// --------------------
	// both words of a pair in one clock
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr_0] <= data_in_0;
			mem[addr_1] <= data_in_1;
		end
	end

	// --------------------
	// read port
	// --------------------
	// registered output, holds a line as long as offsets stay put
	always_ff @(posedge clk) begin
		if (rst) begin
			data_out_0 <= '0;
			data_out_1 <= '0;
		end else if (!we) begin
			data_out_0 <= mem[addr_0];
			data_out_1 <= mem[addr_1];
		end
	end

	// --------------------
	// checks
	// --------------------
	// offsets come from the FSM pair counter as one even/odd pair
	a_offset_pair : assert property (
		@(posedge clk) disable iff (rst)
		offset_1 == offset_0 + 1'b1
	) else $error("offset_1 is not offset_0 plus one");

endmodule

// ==== source/history_read_fsm.sv ====
/* write sequencer and backward frame walk; frame_num and counts must stay stable
   from start to done, num_of_bbox_in_frame above MAX_BBOX is not supported */
`timescale 1ns/1ns
`include "history_buf_cfg.svh"

module history_read_fsm (
	input logic clk,
	input logic rst,
	// core handshake
	input logic start_write,
	input logic start_read,
	input logic rnw_st,
	input logic ready_from_core,
	// consumer takes the current line
	input logic read_new_line,
	input bbox_data_pkg::frame_num_t frame_num,
	input bbox_data_pkg::hist_cnt_t num_of_history_frames,
	input bbox_data_pkg::bbox_cnt_t num_of_bbox_in_frame,
	// memory side
	output logic we,
	output bbox_data_pkg::frame_num_t frame_to_read,
	output bbox_data_pkg::offset_t offset_0,
	output bbox_data_pkg::offset_t offset_1,
	// core and consumer side
	output logic done_write,
	output logic done_read,
	output logic line_valid,
	output logic busy,
	output bbox_data_pkg::hist_cnt_t counter_of_history_frame_to_interface
);

	history_ctrl_pkg::buf_state_e state;
	history_ctrl_pkg::access_e req_access;

	// pair index inside the frame
	bbox_data_pkg::bbox_cnt_t pair_cnt;
	bbox_data_pkg::bbox_cnt_t pair_total;
	logic [`BBOX_CNT_WIDTH:0] bbox_round;
	logic pair_last;

	// h of the frame being read, and the clamped walk length
	bbox_data_pkg::hist_cnt_t hist_cnt;
	bbox_data_pkg::hist_cnt_t walk_len;
	bbox_data_pkg::hist_cnt_t walk_len_next;
	bbox_data_pkg::hist_cnt_t depth_clamp;

	// --------------------
	// derived counts
	// --------------------
	assign req_access = rnw_st ? history_ctrl_pkg::acc_write : history_ctrl_pkg::acc_read;

	// ceil(boxes/2) pairs per frame
	assign bbox_round = {1'b0, num_of_bbox_in_frame} + 1'b1;
	assign pair_total = bbox_round[`BBOX_CNT_WIDTH:1];
	assign pair_last = (pair_cnt == pair_total - 1'b1);

	// never deeper than the ring
	assign depth_clamp = (num_of_history_frames > `HIST_DEPTH_WIDTH'(`HIST_DEPTH)) ?
		`HIST_DEPTH_WIDTH'(`HIST_DEPTH) : num_of_history_frames;

	// no frames before frame 0
	assign walk_len_next = (frame_num < `FRAME_NUM_WIDTH'(depth_clamp)) ?
		frame_num[`HIST_DEPTH_WIDTH-1:0] : depth_clamp;

	// --------------------
	// outputs
	// --------------------
	assign frame_to_read = frame_num - `FRAME_NUM_WIDTH'(hist_cnt);

	// pair k sits at words 2k and 2k+1
	assign offset_0 = {pair_cnt[`OFFSET_WIDTH-2:0], 1'b0};
	assign offset_1 = {pair_cnt[`OFFSET_WIDTH-2:0], 1'b1};

	assign we = (state == history_ctrl_pkg::st_write);
	// data registered one clock after read_line
	assign line_valid = (state == history_ctrl_pkg::st_read_hold);
	assign busy = (state != history_ctrl_pkg::st_idle);
	assign counter_of_history_frame_to_interface = hist_cnt;

	// --------------------
	// state machine
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= history_ctrl_pkg::st_idle;
			pair_cnt <= '0;
			hist_cnt <= '0;
			walk_len <= '0;
			done_write <= 1'b0;
			done_read <= 1'b0;
		end else begin
			// done outputs are single clock pulses
			done_write <= 1'b0;
			done_read <= 1'b0;
			case (state)
				history_ctrl_pkg::st_idle: begin
					hist_cnt <= '0;
					if (start_write && req_access == history_ctrl_pkg::acc_write) begin
						pair_cnt <= '0;
						// empty frame, nothing to store
						if (pair_total == '0)
							done_write <= 1'b1;
						else
							state <= history_ctrl_pkg::st_write;
					end else if (start_read && req_access == history_ctrl_pkg::acc_read) begin
						walk_len <= walk_len_next;
						// empty walk ends right away
						if (walk_len_next == '0 || pair_total == '0) begin
							done_read <= 1'b1;
						end else begin
							hist_cnt <= `HIST_DEPTH_WIDTH'(1);
							state <= history_ctrl_pkg::st_read_wait_ready;
						end
					end
				end
				history_ctrl_pkg::st_write: begin
					if (pair_last) begin
						done_write <= 1'b1;
						state <= history_ctrl_pkg::st_idle;
					end else begin
						pair_cnt <= pair_cnt + 1'b1;
					end
				end
				history_ctrl_pkg::st_read_wait_ready: begin
					// core gates each frame start
					if (ready_from_core) begin
						pair_cnt <= '0;
						state <= history_ctrl_pkg::st_read_line;
					end
				end
				history_ctrl_pkg::st_read_line: begin
					state <= history_ctrl_pkg::st_read_hold;
				end
				history_ctrl_pkg::st_read_hold: begin
					// line held until consumed
					if (read_new_line) begin
						if (!pair_last) begin
							pair_cnt <= pair_cnt + 1'b1;
							state <= history_ctrl_pkg::st_read_line;
						end else if (hist_cnt == walk_len) begin
							done_read <= 1'b1;
							hist_cnt <= '0;
							state <= history_ctrl_pkg::st_idle;
						end else begin
							state <= history_ctrl_pkg::st_read_next_frame;
						end
					end
				end
				history_ctrl_pkg::st_read_next_frame: begin
					// one frame older
					hist_cnt <= hist_cnt + 1'b1;
					state <= history_ctrl_pkg::st_read_wait_ready;
				end
				default: begin
					state <= history_ctrl_pkg::st_idle;
				end
			endcase
		end
	end

	// --------------------
	// checks
	// --------------------
	// consumer may only take a line that is on the bus
	a_line_taken_valid : assert property (
		@(posedge clk) disable iff (rst)
		read_new_line |-> line_valid
	) else $error("read_new_line without line_valid");

	a_done_exclusive : assert property (
		@(posedge clk) disable iff (rst)
		!(done_read && done_write)
	) else $error("done_read and done_write in the same clock");

endmodule

// ==== source/history_buffer.sv ====
/* history buffer top; holds frame_num and counts stable from start to done,
   start pulses while busy are dropped */
`timescale 1ns/1ns

module history_buffer (
	input logic clk,
	input logic rst,
	// core control
	input logic start_write,
	input logic start_read,
	input logic rnw_st,
	input logic ready_from_core,
	input logic read_new_line,
	// frame context
	input bbox_data_pkg::frame_num_t frame_num,
	input bbox_data_pkg::hist_cnt_t num_of_history_frames,
	input bbox_data_pkg::bbox_cnt_t num_of_bbox_in_frame,
	// pair from the PEs
	input bbox_data_pkg::bbox_t data_in_0,
	input bbox_data_pkg::bbox_t data_in_1,
	output logic done_write,
	output logic done_read,
	output logic line_valid,
	output logic busy,
	// line to the similarity metric
	output bbox_data_pkg::bbox_t data_out_0,
	output bbox_data_pkg::bbox_t data_out_1,
	output bbox_data_pkg::hist_cnt_t counter_of_history_frame_to_interface
);

	logic we;
	history_ctrl_pkg::access_e mem_access;
	bbox_data_pkg::frame_num_t frame_to_read;
	bbox_data_pkg::frame_num_t mem_frame_num;
	bbox_data_pkg::offset_t offset_0;
	bbox_data_pkg::offset_t offset_1;

	// --------------------
	// frame select
	// --------------------
	// write goes to the current frame, read to frame_num - h
	assign mem_access = we ? history_ctrl_pkg::acc_write : history_ctrl_pkg::acc_read;
	assign mem_frame_num = (mem_access == history_ctrl_pkg::acc_write) ? frame_num : frame_to_read;

	// --------------------
	// blocks
	// --------------------
	history_frame_mem mem_i (
		.clk        (clk),
		.rst        (rst),
		.frame_num  (mem_frame_num),
		.we         (we),
		.offset_0   (offset_0),
		.offset_1   (offset_1),
		.data_in_0  (data_in_0),
		.data_in_1  (data_in_1),
		.data_out_0 (data_out_0),
		.data_out_1 (data_out_1)
	);

	history_read_fsm fsm_i (
		.clk                                   (clk),
		.rst                                   (rst),
		.start_write                           (start_write),
		.start_read                            (start_read),
		.rnw_st                                (rnw_st),
		.ready_from_core                       (ready_from_core),
		.read_new_line                         (read_new_line),
		.frame_num                             (frame_num),
		.num_of_history_frames                 (num_of_history_frames),
		.num_of_bbox_in_frame                  (num_of_bbox_in_frame),
		.we                                    (we),
		.frame_to_read                         (frame_to_read),
		.offset_0                              (offset_0),
		.offset_1                              (offset_1),
		.done_write                            (done_write),
		.done_read                             (done_read),
		.line_valid                            (line_valid),
		.busy                                  (busy),
		.counter_of_history_frame_to_interface (counter_of_history_frame_to_interface)
	);

endmodule

// ==== sim/history_buffer_tb.sv ====
/* reads sim/history_trace.txt relative to the project root; expected lines come from
   the trace, consumer and ready stalls are random from a fixed seed */
`timescale 1ns/1ns

module history_buffer_tb;

	localparam int SEED = 84602;
	// longest wait in clocks for any DUT event
	localparam int WAIT_LIMIT = 64;
	localparam int MAX_LINES = 64;

	logic clk;
	logic rst;
	logic start_write;
	logic start_read;
	logic rnw_st;
	logic read_new_line;
	logic ready_from_core;
	bbox_data_pkg::frame_num_t frame_num;
	bbox_data_pkg::hist_cnt_t num_of_history_frames;
	bbox_data_pkg::bbox_cnt_t num_of_bbox_in_frame;
	bbox_data_pkg::bbox_t data_in_0;
	bbox_data_pkg::bbox_t data_in_1;
	logic done_write;
	logic done_read;
	logic line_valid;
	logic busy;
	bbox_data_pkg::bbox_t data_out_0;
	bbox_data_pkg::bbox_t data_out_1;
	bbox_data_pkg::hist_cnt_t hist_counter;

	int errors;
	int timeouts;
	bit aborted;
	// upper bound of every random stall
	int pause_max;

	// pairs of the frame being written
	bbox_data_pkg::bbox_t wr_d0 [0:7];
	bbox_data_pkg::bbox_t wr_d1 [0:7];
	// expected lines of the current walk
	int exp_h [0:MAX_LINES-1];
	bbox_data_pkg::bbox_t exp_d0 [0:MAX_LINES-1];
	bbox_data_pkg::bbox_t exp_d1 [0:MAX_LINES-1];

	history_buffer dut_i (
		.clk                                   (clk),
		.rst                                   (rst),
		.start_write                           (start_write),
		.start_read                            (start_read),
		.rnw_st                                (rnw_st),
		.ready_from_core                       (ready_from_core),
		.read_new_line                         (read_new_line),
		.frame_num                             (frame_num),
		.num_of_history_frames                 (num_of_history_frames),
		.num_of_bbox_in_frame                  (num_of_bbox_in_frame),
		.data_in_0                             (data_in_0),
		.data_in_1                             (data_in_1),
		.done_write                            (done_write),
		.done_read                             (done_read),
		.line_valid                            (line_valid),
		.busy                                  (busy),
		.data_out_0                            (data_out_0),
		.data_out_1                            (data_out_1),
		.counter_of_history_frame_to_interface (hist_counter)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// helpers
	// --------------------
	// outputs settle by 1 ns after the edge and inputs change here too
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic report_timeout(input string what);
		history_ctrl_pkg::buf_state_e st;
		st = dut_i.fsm_i.state;
		timeouts++;
		aborted = 1'b1;
		$display("timeout: no %s within %0d clocks, FSM in %s", what, WAIT_LIMIT, st.name());
	endtask

	// pairs sampled one per clock after the start and done one clock after the last
	task automatic write_frame(input int frame, input int count);
		int npairs;
		int cyc;
		bit seen;
		npairs = (count + 1) / 2;
		seen = 1'b0;
		frame_num = bbox_data_pkg::frame_num_t'(frame);
		num_of_bbox_in_frame = bbox_data_pkg::bbox_cnt_t'(count);
		rnw_st = 1'b1;
		start_write = 1'b1;
		for (cyc = 1; cyc <= WAIT_LIMIT && !seen; cyc++) begin
			next_cycle();
			start_write = 1'b0;
			data_in_0 = (cyc <= npairs) ? wr_d0[cyc-1] : '0;
			data_in_1 = (cyc <= npairs) ? wr_d1[cyc-1] : '0;
			if (done_write === 1'b1) begin
				seen = 1'b1;
				if (cyc != npairs + 1)
					report_mismatch("done_write latency", cyc, npairs + 1);
				if (busy !== 1'b0)
					report_mismatch("busy at done_write", 32'(busy), 0);
			end else if (busy !== 1'b1) begin
				report_mismatch("busy before done_write", 32'(busy), 1);
			end
		end
		if (!seen)
			report_timeout("done_write");
	endtask

	// frame h starts once the counter steps and its line follows ready by two clocks
	task automatic start_frame(input int h);
		int n;
		int delay;
		n = 0;
		while (hist_counter !== bbox_data_pkg::hist_cnt_t'(h) && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (hist_counter !== bbox_data_pkg::hist_cnt_t'(h)) begin
			report_timeout("history counter step");
		end else begin
			delay = $urandom % (pause_max + 1);
			repeat (delay) begin
				next_cycle();
				if (line_valid !== 1'b0)
					report_mismatch("line_valid while not ready", 32'(line_valid), 0);
			end
			ready_from_core = 1'b1;
			n = 0;
			while (line_valid !== 1'b1 && n < WAIT_LIMIT) begin
				next_cycle();
				n++;
			end
			ready_from_core = 1'b0;
			if (line_valid !== 1'b1)
				report_timeout("line_valid after ready");
			else if (n != 2)
				report_mismatch("line_valid latency after ready", n, 2);
		end
	endtask

	// line must stay put until the consumer takes it
	task automatic take_line(input int i, input bit last);
		int n;
		int delay;
		delay = $urandom % (pause_max + 1);
		for (n = 0; n <= delay; n++) begin
			if (n > 0)
				next_cycle();
			if (line_valid !== 1'b1)
				report_mismatch("line_valid during hold", 32'(line_valid), 1);
			if (busy !== 1'b1)
				report_mismatch("busy during hold", 32'(busy), 1);
			if (data_out_0 !== exp_d0[i])
				report_mismatch("data_out_0", data_out_0, exp_d0[i]);
			if (data_out_1 !== exp_d1[i])
				report_mismatch("data_out_1", data_out_1, exp_d1[i]);
			if (hist_counter !== bbox_data_pkg::hist_cnt_t'(exp_h[i]))
				report_mismatch("history counter", 32'(hist_counter), exp_h[i]);
			if (done_read !== 1'b0)
				report_mismatch("done_read during hold", 32'(done_read), 0);
		end
		read_new_line = 1'b1;
		next_cycle();
		read_new_line = 1'b0;
		if (line_valid !== 1'b0)
			report_mismatch("line_valid after read_new_line", 32'(line_valid), 0);
		if (done_read !== last)
			report_mismatch("done_read after read_new_line", 32'(done_read), 32'(last));
		if (last && busy !== 1'b0)
			report_mismatch("busy after done_read", 32'(busy), 0);
	endtask

	task automatic read_walk(input int frame, input int depth, input int count, input int nl);
		int i;
		int n;
		int cur_h;
		frame_num = bbox_data_pkg::frame_num_t'(frame);
		num_of_history_frames = bbox_data_pkg::hist_cnt_t'(depth);
		num_of_bbox_in_frame = bbox_data_pkg::bbox_cnt_t'(count);
		rnw_st = 1'b0;
		ready_from_core = 1'b0;
		start_read = 1'b1;
		next_cycle();
		start_read = 1'b0;
		cur_h = 0;
		if (nl == 0) begin
			// empty walk ends with done one clock after the start
			if (done_read !== 1'b1)
				report_mismatch("done_read on empty walk", 32'(done_read), 1);
			if (line_valid !== 1'b0 || busy !== 1'b0)
				report_mismatch("line_valid/busy on empty walk", {line_valid, busy}, 0);
		end
		for (i = 0; i < nl && !aborted; i++) begin
			if (exp_h[i] != cur_h) begin
				cur_h = exp_h[i];
				start_frame(cur_h);
			end else begin
				n = 0;
				while (line_valid !== 1'b1 && n < WAIT_LIMIT) begin
					next_cycle();
					n++;
				end
				if (line_valid !== 1'b1)
					report_timeout("next line_valid");
				else if (n != 1)
					report_mismatch("gap between lines", n, 1);
			end
			if (!aborted)
				take_line(i, i == nl - 1);
		end
	endtask

	// --------------------
	// trace player
	// --------------------
	initial begin
		int fd;
		int c;
		int code;
		int k;
		int fr;
		int depth;
		int cnt;
		int nl;
		bbox_data_pkg::bbox_t w0;
		bbox_data_pkg::bbox_t w1;
		errors = 0;
		timeouts = 0;
		aborted = 1'b0;
		pause_max = 0;
		start_write = 1'b0;
		start_read = 1'b0;
		rnw_st = 1'b0;
		read_new_line = 1'b0;
		ready_from_core = 1'b0;
		frame_num = '0;
		num_of_history_frames = '0;
		num_of_bbox_in_frame = '0;
		data_in_0 = '0;
		data_in_1 = '0;
		rst = 1'b1;
		void'($urandom(SEED));
		repeat (2) next_cycle();
		rst = 1'b0;
		if ({done_write, done_read, line_valid, busy} !== 4'b0)
			report_mismatch("done/line_valid/busy after reset",
				{done_write, done_read, line_valid, busy}, 0);
		if (hist_counter !== '0)
			report_mismatch("history counter after reset", 32'(hist_counter), 0);
		fd = $fopen("sim/history_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file sim/history_trace.txt");
			aborted = 1'b1;
		end else begin
			c = $fgetc(fd);
			while (c != -1 && !aborted) begin
				if (c == "#") begin
					while (c != -1 && c != 8'h0a)
						c = $fgetc(fd);
				end else if (c == "P") begin
					code = $fscanf(fd, "%d", pause_max);
				end else if (c == "W") begin
					code = $fscanf(fd, "%d %d", fr, cnt);
					for (k = 0; k < (cnt + 1) / 2 && k < 8; k++) begin
						code = $fscanf(fd, "%h %h", w0, w1);
						wr_d0[k] = w0;
						wr_d1[k] = w1;
					end
					write_frame(fr, cnt);
				end else if (c == "R") begin
					code = $fscanf(fd, "%d %d %d %d", fr, depth, cnt, nl);
					if (code != 4 || nl > MAX_LINES) begin
						$display("trace read record is malformed or too long");
						aborted = 1'b1;
					end else begin
						for (k = 0; k < nl; k++)
							code = $fscanf(fd, "%d %h %h", exp_h[k], exp_d0[k], exp_d1[k]);
						read_walk(fr, depth, cnt, nl);
					end
				end
				c = $fgetc(fd);
			end
			$fclose(fd);
		end
		$display("summary: mismatches %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0 && !aborted) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== sim/history_trace.txt ====
# W frame boxes, then ceil(boxes/2) pairs: word_even word_odd (hex) ; P max_stall_clocks
# R frame depth boxes lines, then per line: h word_even word_odd (h decimal, words hex)
P 0
W 0 5 a0000000 a0000001 a0000002 a0000003 a0000004 a0000005
W 1 4 a1000000 a1000001 a1000002 a1000003
W 2 3 a2000000 a2000001 a2000002 a2000003
# clamped walk, only frames 1 and 0 exist
R 2 4 4 4
1 a1000000 a1000001
1 a1000002 a1000003
2 a0000000 a0000001
2 a0000002 a0000003
# no history at frame 0
R 0 4 4 0
W 3 4 a3000000 a3000001 a3000002 a3000003
W 4 4 a4000000 a4000001 a4000002 a4000003
P 5
R 5 4 4 8
1 a4000000 a4000001
1 a4000002 a4000003
2 a3000000 a3000001
2 a3000002 a3000003
3 a2000000 a2000001
3 a2000002 a2000003
4 a1000000 a1000001
4 a1000002 a1000003
# frame 5 lands in the slot of frame 1
W 5 4 b5000000 b5000001 b5000002 b5000003
P 3
R 6 4 4 8
1 b5000000 b5000001
1 b5000002 b5000003
2 a4000000 a4000001
2 a4000002 a4000003
3 a3000000 a3000001
3 a3000002 a3000003
4 a2000000 a2000001
4 a2000002 a2000003
# depth 7 clamps to the ring, one pair per frame
R 6 7 1 4
1 b5000000 b5000001
2 a4000000 a4000001
3 a3000000 a3000001
4 a2000000 a2000001
# slot 0 mixes frame 4 pairs with the third pair left by frame 0
R 1 1 5 3
1 a4000000 a4000001
1 a4000002 a4000003
1 a0000004 a0000005

// ==== tb.f ====
+incdir+include
source/bbox_data_pkg.sv
source/history_ctrl_pkg.sv
source/history_frame_mem.sv
source/history_read_fsm.sv
source/history_buffer.sv
sim/history_buffer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the history buffer testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=history_buffer_sim
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module history_buffer_tb -Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$build_dir/$sim_bin" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the log decides, not the exit status alone
if grep -qx "all tests passed" "$log"; then
	echo "simulation PASS"
	exit 0
else
	echo "simulation FAIL, see $log"
	exit 1
fi
